// File: build.f
hw/spi_mem_pkg.sv
hw/spi_ctrl_if.sv
hw/spi_pin_sync.sv
hw/spi_shift_reg.sv
hw/spi_xfer_fsm.sv
hw/spi_data_mem.sv
hw/spi_mem_top.sv
dv/spi_mem_asserts.sv
dv/spi_mem_tb.sv

// File: dv/spi_mem_asserts.sv
`timescale 1ns/1ps

module spi_mem_asserts (
    input logic                     sclk,
    input logic                     rst_n,
    input logic                     cs_n,
    input logic                     sck,
    input logic                     miso,
    input logic                     miso_oe,
    input spi_mem_pkg::xfer_state_e state
);

    int unsigned fail_count = 0;    // read by the testbench when the run ends

    // five samples of cs_n high leave no room for a driven miso
    oe_off_after_cs: assert property (@(posedge sclk) disable iff (!rst_n)
        cs_n && $past(cs_n, 1) && $past(cs_n, 2) && $past(cs_n, 3) && $past(cs_n, 4)
        |-> !miso_oe)
    else begin
        $error("miso_oe still high more than 4 cycles after cs_n went high");
        fail_count++;
    end

    // the first four samples after reset release
    oe_off_after_reset: assert property (@(posedge sclk)
        rst_n && !($past(rst_n, 1) && $past(rst_n, 2) && $past(rst_n, 3)
                   && $past(rst_n, 4))
        |-> !miso_oe)
    else begin
        $error("miso_oe high within 4 cycles of reset release");
        fail_count++;
    end

    // mode 0, the master samples while sck is high
    miso_stable_sck_high: assert property (@(posedge sclk) disable iff (!rst_n)
        sck && miso_oe |-> $stable(miso))
    else begin
        $error("miso changed while sck was high and miso_oe was set");
        fail_count++;
    end

    // a released chip select returns the controller to idle from any state
    idle_after_cs: assert property (@(posedge sclk) disable iff (!rst_n)
        cs_n && $past(cs_n, 1) && $past(cs_n, 2) && $past(cs_n, 3) && $past(cs_n, 4)
        |-> state == spi_mem_pkg::reset_idle)
    else begin
        $error("controller not back in reset_idle 4 cycles after cs_n went high");
        fail_count++;
    end

endmodule

bind spi_mem_top spi_mem_asserts i_spi_mem_asserts (
    .sclk    (sclk),
    .rst_n   (rst_n),
    .cs_n    (cs_n),
    .sck     (sck),
    .miso    (miso),
    .miso_oe (miso_oe),
    .state   (i_spi_xfer_fsm.state)
);

// File: dv/spi_mem_tb.sv
`timescale 1ns/1ps

module spi_mem_tb;

    localparam int half_period = 10;    // sclk cycles per sck half period
    localparam int n_xfers     = 44;    // transactions over all tests

    logic sclk;
    logic rst_n;
    logic cs_n;
    logic sck;
    logic mosi;
    logic miso;
    logic miso_oe;

    logic [spi_mem_pkg::data_w-1:0] model [spi_mem_pkg::mem_depth];   // last write per address
    int errors;
    int errors_at_start;
    int tests_passed;
    int tests_failed;

    spi_mem_top i_spi_mem_top (
        .sclk    (sclk),
        .rst_n   (rst_n),
        .cs_n    (cs_n),
        .sck     (sck),
        .mosi    (mosi),
        .miso    (miso),
        .miso_oe (miso_oe)
    );

    initial begin
        sclk = 1'b0;
        forever #10 sclk = ~sclk;
    end

    // each transaction is under 20 bit times of 20 sclk cycles
    initial begin
        #(n_xfers * 20 * 20 * 20 + 50_000);
        $display("timeout: the SPI transactions did not complete in the expected time");
        $display("TESTBENCH FAILED");
        $finish;
    end

    function automatic int total_errors();
        return errors + int'(i_spi_mem_top.i_spi_mem_asserts.fail_count);
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge sclk);
        #2;                             // inputs change just after the edge
    endtask

    task automatic check_oe(input logic exp, input string phase);
        assert (miso_oe === exp) else begin
            $display("mismatch at %0t ns: miso_oe in %s is %b, expected %b",
                     $time, phase, miso_oe, exp);
            errors++;
        end
    endtask

    // one sck period, miso is taken just before the rising edge
    task automatic clock_bit(input logic bit_out, input logic exp_rise, input logic exp_fall,
                             input string phase, output logic bit_in);
        mosi = bit_out;
        wait_cycles(half_period);
        check_oe(exp_rise, phase);
        bit_in = miso;
        sck = 1'b1;
        wait_cycles(half_period);
        check_oe(exp_fall, phase);
        sck = 1'b0;
    endtask

    // raise cs_n, the driver must be off within 4 cycles
    task automatic release_cs();
        wait_cycles(half_period);
        cs_n = 1'b1;
        wait_cycles(4);
        check_oe(1'b0, "cs_n release");
        wait_cycles(2 * half_period);
    endtask

    task automatic spi_transfer(input logic [6:0] addr, input logic rd, input logic [7:0] wdata,
                                input int data_bits, input logic hold_cs,
                                output logic [7:0] rdata);
        logic [7:0] cmd;
        logic       b;
        cmd   = {addr, rd};
        rdata = '0;
        cs_n  = 1'b0;
        for (int i = 7; i >= 0; i--) begin
            clock_bit(cmd[i], 1'b0, (i == 0) && rd, "command phase", b);
        end
        for (int i = 7; i >= 8 - data_bits; i--) begin
            clock_bit(wdata[i], rd, rd && (i != 0), "data phase", b);
            rdata[i] = b;
        end
        if (!hold_cs) begin
            release_cs();
        end
    endtask

    task automatic spi_write(input logic [6:0] addr, input logic [7:0] data);
        logic [7:0] unused;
        spi_transfer(addr, 1'b0, data, 8, 1'b0, unused);
        model[addr] = data;
    endtask

    task automatic spi_read(input logic [6:0] addr);
        logic [7:0] got;
        spi_transfer(addr, 1'b1, 8'h00, 8, 1'b0, got);
        assert (got === model[addr]) else begin
            $display("mismatch at %0t ns: miso from address %0d is %02h, expected %02h",
                     $time, addr, got, model[addr]);
            errors++;
        end
    endtask

    // cs_n rises after four data bits, nothing may be stored
    task automatic spi_abort(input logic [6:0] addr, input logic rd, input logic [7:0] data);
        logic [7:0] unused;
        spi_transfer(addr, rd, data, 4, 1'b0, unused);
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        wait_cycles(5);
        rst_n = 1'b1;
        for (int i = 0; i < 4; i++) begin
            wait_cycles(1);
            check_oe(1'b0, "reset release");
        end
    endtask

    // reset hits the read data phase while cs_n is still low and miso_oe is high
    task automatic reset_during_read(input logic [6:0] addr);
        logic [7:0] unused;
        spi_transfer(addr, 1'b1, 8'h00, 4, 1'b1, unused);
        apply_reset();
        release_cs();
    endtask

    task automatic finish_test(input string name);
        if (total_errors() == errors_at_start) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed", name);
        end
        errors_at_start = total_errors();
    endtask

    initial begin
        logic [6:0] addr_list [16];
        void'($urandom(32'h2dc7_7d14));
        rst_n           = 1'b0;
        cs_n            = 1'b1;
        sck             = 1'b0;
        mosi            = 1'b0;
        errors          = 0;
        errors_at_start = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        apply_reset();

        spi_write(7'h2a, 8'hc5);
        spi_read(7'h2a);
        finish_test("write_readback");

        for (int i = 0; i < 16; i++) begin
            addr_list[i] = 7'($urandom_range(127, 0));
            spi_write(addr_list[i], 8'($urandom_range(255, 0)));
        end
        for (int i = 0; i < 16; i++) begin
            spi_read(addr_list[i]);
        end
        finish_test("random_fill");

        spi_write(7'h11, 8'h3c);
        spi_abort(7'h11, 1'b0, 8'hff);
        spi_read(7'h11);
        finish_test("abort_write");

        spi_write(7'h00, 8'h81);        // oe sampled on every sck edge in both
        spi_read(7'h00);
        finish_test("oe_phases");

        spi_abort(7'h2a, 1'b1, 8'h00);  // cs_n rises while miso_oe is high
        reset_during_read(7'h2a);
        spi_read(7'h2a);
        spi_write(7'h7f, 8'h5a);
        spi_read(7'h7f);
        finish_test("oe_recovery");

        $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && total_errors() == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: hw/spi_ctrl_if.sv
`timescale 1ns/1ps

interface spi_ctrl_if;

    logic                   sr_we;      // load shift register from memory
    logic                   addr_we;    // latch the command byte
    logic                   dm_we;      // write shift register into memory
    logic                   miso_bufe;  // miso driver enable, held in the read data phase
    logic                   byte_done;  // eighth bit of a byte has been sampled
    spi_mem_pkg::cmd_byte_u cmd;        // latched command byte

    modport ctrl (
        output sr_we, addr_we, dm_we, miso_bufe,
        input  byte_done, cmd
    );

    modport dp (
        input  sr_we, addr_we, miso_bufe,
        output byte_done, cmd
    );

    modport mem (
        input  dm_we, cmd
    );

endinterface

// File: hw/spi_data_mem.sv
`timescale 1ns/1ps

module spi_data_mem (
    input  logic                           sclk,
    input  logic [spi_mem_pkg::data_w-1:0] wr_data,
    output logic [spi_mem_pkg::data_w-1:0] rd_data,
    spi_ctrl_if.mem                        ctl
);

    logic [spi_mem_pkg::data_w-1:0] mem [spi_mem_pkg::mem_depth];

    // single port, the latched command address serves both write and read
    always_ff @(posedge sclk) begin
        if (ctl.dm_we) begin
            mem[ctl.cmd.fields.addr] <= wr_data;
        end
        rd_data <= mem[ctl.cmd.fields.addr];    // valid one cycle after the address changes
    end

endmodule

// File: hw/spi_mem_pkg.sv
package spi_mem_pkg;

    localparam int addr_w      = 7;    // 128 byte locations
    localparam int data_w      = 8;    // one SPI byte
    localparam int mem_depth   = 128;
    localparam int bit_count_w = 4;    // counts the bits of one byte

    // transaction controller states
    typedef enum logic [2:0] {
        reset_idle = 3'd0,             // waiting for a new cs_n assertion
        addr_load  = 3'd1,             // shifting in the command byte
        branch     = 3'd2,             // one cycle to decode the read/write bit
        write_data = 3'd3,             // shifting in the byte to store
        read_data  = 3'd4              // shifting out the addressed byte
    } xfer_state_e;

    // First byte of a transaction. It arrives as a plain byte and is then
    // decoded as address plus direction bit
    typedef union packed {
        logic [data_w-1:0] raw;        // byte as it came off mosi
        struct packed {
            logic [addr_w-1:0] addr;   // first seven bits on the wire
            logic              rd;     // last bit, 1 selects a read
        } fields;
    } cmd_byte_u;

endpackage

// File: hw/spi_mem_top.sv
`timescale 1ns/1ps

module spi_mem_top (
    input  logic sclk,
    input  logic rst_n,
    input  logic cs_n,
    input  logic sck,
    input  logic mosi,
    output logic miso,
    output logic miso_oe
);

    logic                           sck_rise;
    logic                           sck_fall;
    logic                           cs_active;
    logic                           mosi_s;
    logic                           miso_bit;
    logic [spi_mem_pkg::data_w-1:0] rd_data;
    logic [spi_mem_pkg::data_w-1:0] wr_data;

    spi_ctrl_if i_ctrl_if ();   // strobes and status between controller and datapath

    spi_pin_sync i_spi_pin_sync (
        .sclk      (sclk),
        .rst_n     (rst_n),
        .cs_n      (cs_n),
        .sck       (sck),
        .mosi      (mosi),
        .sck_rise  (sck_rise),
        .sck_fall  (sck_fall),
        .cs_active (cs_active),
        .mosi_s    (mosi_s)
    );

    spi_shift_reg i_spi_shift_reg (
        .sclk      (sclk),
        .rst_n     (rst_n),
        .sck_rise  (sck_rise),
        .sck_fall  (sck_fall),
        .cs_active (cs_active),
        .mosi_s    (mosi_s),
        .rd_data   (rd_data),
        .wr_data   (wr_data),
        .miso_bit  (miso_bit),
        .ctl       (i_ctrl_if.dp)
    );

    spi_xfer_fsm i_spi_xfer_fsm (
        .sclk      (sclk),
        .rst_n     (rst_n),
        .cs_active (cs_active),
        .ctl       (i_ctrl_if.ctrl)
    );

    spi_data_mem i_spi_data_mem (
        .sclk      (sclk),
        .wr_data   (wr_data),
        .rd_data   (rd_data),
        .ctl       (i_ctrl_if.mem)
    );

    assign miso    = miso_bit;
    assign miso_oe = i_ctrl_if.miso_bufe;   // pad driver enable

endmodule

// File: hw/spi_pin_sync.sv
`timescale 1ns/1ps

module spi_pin_sync (
    input  logic sclk,
    input  logic rst_n,
    input  logic cs_n,
    input  logic sck,
    input  logic mosi,
    output logic sck_rise,
    output logic sck_fall,
    output logic cs_active,
    output logic mosi_s
);

    logic [1:0] sck_sync;   // bit 1 is the second flop
    logic [1:0] cs_n_sync;
    logic [1:0] mosi_sync;
    logic       sck_q;      // previous synchronized sck for edge detection

    // two-flop synchronizers, cs_n idles high so it resets to inactive
    always_ff @(posedge sclk or negedge rst_n) begin
        if (!rst_n) begin
            sck_sync  <= 2'b00;
            cs_n_sync <= 2'b11;
            mosi_sync <= 2'b00;
        end else begin
            sck_sync  <= {sck_sync[0], sck};
            cs_n_sync <= {cs_n_sync[0], cs_n};
            mosi_sync <= {mosi_sync[0], mosi};
        end
    end

    // Third stage registers every output so that edges, cs level and
    // the mosi bit all appear exactly three sclk cycles after the pins
    always_ff @(posedge sclk or negedge rst_n) begin
        if (!rst_n) begin
            sck_q     <= 1'b0;
            sck_rise  <= 1'b0;
            sck_fall  <= 1'b0;
            cs_active <= 1'b0;
            mosi_s    <= 1'b0;
        end else begin
            sck_q     <= sck_sync[1];
            sck_rise  <= sck_sync[1] & ~sck_q;   // low to high seen on the synced pin
            sck_fall  <= ~sck_sync[1] & sck_q;
            cs_active <= ~cs_n_sync[1];          // chip select is active low on the pin
            mosi_s    <= mosi_sync[1];
        end
    end

endmodule

// File: hw/spi_shift_reg.sv
`timescale 1ns/1ps

module spi_shift_reg (
    input  logic                           sclk,
    input  logic                           rst_n,
    input  logic                           sck_rise,
    input  logic                           sck_fall,
    input  logic                           cs_active,
    input  logic                           mosi_s,
    input  logic [spi_mem_pkg::data_w-1:0] rd_data,
    output logic [spi_mem_pkg::data_w-1:0] wr_data,
    output logic                           miso_bit,
    spi_ctrl_if.dp                         ctl
);

    logic [spi_mem_pkg::data_w-1:0]      sr;        // serial in, parallel out and in
    logic [spi_mem_pkg::bit_count_w-1:0] bit_cnt;   // bits sampled in the current byte

    // bit counter, restarts on every byte and whenever cs is released
    always_ff @(posedge sclk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt       <= '0;
            ctl.byte_done <= 1'b0;
        end else if (!cs_active) begin
            bit_cnt       <= '0;                    // an aborted byte never completes
            ctl.byte_done <= 1'b0;
        end else begin
            ctl.byte_done <= 1'b0;
            if (sck_rise) begin
                if (bit_cnt == spi_mem_pkg::bit_count_w'(spi_mem_pkg::data_w - 1)) begin
                    bit_cnt       <= '0;
                    ctl.byte_done <= 1'b1;          // pulses together with the full byte in sr
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    // MSB first, so new bits enter at the bottom
    always_ff @(posedge sclk) begin
        if (ctl.sr_we) begin
            sr <= rd_data;                          // read data for the master
        end else if (sck_rise) begin
            sr <= {sr[spi_mem_pkg::data_w-2:0], mosi_s};
        end
    end

    // address latch holding the command byte for the rest of the transaction
    always_ff @(posedge sclk) begin
        if (ctl.addr_we) begin
            ctl.cmd.raw <= sr;
        end
    end

    // Mode 0 output. The bit moves only after a falling sck edge, so it is
    // stable while the master samples on the rising edge
    always_ff @(posedge sclk or negedge rst_n) begin
        if (!rst_n) begin
            miso_bit <= 1'b0;
        end else if (ctl.miso_bufe && sck_fall) begin
            miso_bit <= sr[spi_mem_pkg::data_w-1];
        end
    end

    assign wr_data = sr;                            // full byte when dm_we fires

endmodule

// File: hw/spi_xfer_fsm.sv
`timescale 1ns/1ps

module spi_xfer_fsm (
    input  logic     sclk,
    input  logic     rst_n,
    input  logic     cs_active,
    spi_ctrl_if.ctrl ctl
);

    spi_mem_pkg::xfer_state_e state;
    spi_mem_pkg::xfer_state_e state_nxt;
    logic                     cs_q;     // cs_active one cycle earlier

    // state register and the registered strobes
    always_ff @(posedge sclk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= spi_mem_pkg::reset_idle;
            cs_q      <= 1'b0;
            ctl.sr_we <= 1'b0;
        end else begin
            state <= state_nxt;
            cs_q  <= cs_active;
            // The memory output follows the new address one cycle after
            // branch, so the load into the shift register waits one cycle
            ctl.sr_we <= (state == spi_mem_pkg::branch) && ctl.cmd.fields.rd;
        end
    end

    // next state, byte_done from the shift register paces both phases
    always_comb begin
        state_nxt = state;
        if (!cs_active) begin
            state_nxt = spi_mem_pkg::reset_idle;            // abort from anywhere
        end else begin
            case (state)
                spi_mem_pkg::reset_idle: begin
                    // only a fresh cs assertion starts a transaction
                    if (!cs_q) begin
                        state_nxt = spi_mem_pkg::addr_load;
                    end
                end
                spi_mem_pkg::addr_load: begin
                    if (ctl.byte_done) begin
                        state_nxt = spi_mem_pkg::branch;
                    end
                end
                spi_mem_pkg::branch: begin
                    if (ctl.cmd.fields.rd) begin
                        state_nxt = spi_mem_pkg::read_data;
                    end else begin
                        state_nxt = spi_mem_pkg::write_data;
                    end
                end
                spi_mem_pkg::write_data: begin
                    if (ctl.byte_done) begin
                        state_nxt = spi_mem_pkg::reset_idle;  // one byte per transaction
                    end
                end
                spi_mem_pkg::read_data: begin
                    if (ctl.byte_done) begin
                        state_nxt = spi_mem_pkg::reset_idle;
                    end
                end
                default: begin
                    state_nxt = spi_mem_pkg::reset_idle;
                end
            endcase
        end
    end

    // strobes that must line up with byte_done are decoded directly
    assign ctl.addr_we = (state == spi_mem_pkg::addr_load) && ctl.byte_done;
    assign ctl.dm_we   = (state == spi_mem_pkg::write_data) && ctl.byte_done && cs_active;

    // cs_active in the term lets miso_oe drop one cycle before the state does
    assign ctl.miso_bufe = (state == spi_mem_pkg::read_data) && cs_active;

endmodule
